//--- build.f
logic/thor_pkg.sv
logic/thor_alu.sv
logic/thor_regfile.sv
logic/thor_operand_fetch.sv
logic/thor_writeback.sv
logic/thor_exec_top.sv
verification/tb_clock_gen.sv
verification/thor_exec_assertions.sv
verification/tb_thor_exec.sv

//--- logic/thor_alu.sv
// Purely combinational; unknown opcodes yield the DEAD pattern, upper compare bits are zero

`timescale 1ns/1ns

module thor_alu (
  input  thor_pkg::alu_op_e                  op,
  input  logic [thor_pkg::data_w-1:0]        a,
  input  logic [thor_pkg::data_w-1:0]        b,
  input  logic [thor_pkg::data_w-1:0]        c,
  input  logic [thor_pkg::data_w-1:0]        imm,
  input  logic [thor_pkg::data_w-1:0]        pc,
  input  logic [thor_pkg::insn_size_w-1:0]   insn_size,
  output logic [thor_pkg::data_w-1:0]        result
);

  // Signed views for compare
  logic signed [thor_pkg::data_w-1:0] a_s;
  logic signed [thor_pkg::data_w-1:0] b_s;
  logic signed [thor_pkg::data_w-1:0] imm_s;

  // Instruction size widened to data width
  logic [thor_pkg::data_w-1:0] size_ext;

  assign a_s = a;
  assign b_s = b;
  assign imm_s = imm;
  assign size_ext = {{(thor_pkg::data_w - thor_pkg::insn_size_w){1'b0}}, insn_size};

  // ======================================================================
  // Result select
  // ======================================================================
  always_comb begin
    result = '0;
    case (op)
      thor_pkg::op_ldi:     result = imm;
      // Scaled adds, register form
      thor_pkg::op_addu2:   result = (a << 1) + b;
      thor_pkg::op_addu4:   result = (a << 2) + b;
      thor_pkg::op_addu8:   result = (a << 3) + b;
      thor_pkg::op_addu16:  result = (a << 4) + b;
      // Scaled adds, immediate form
      thor_pkg::op_addui2:  result = (a << 1) + imm;
      thor_pkg::op_addui4:  result = (a << 2) + imm;
      thor_pkg::op_addui8:  result = (a << 3) + imm;
      thor_pkg::op_addui16: result = (a << 4) + imm;
      thor_pkg::op_add:     result = a + b;
      thor_pkg::op_sub:     result = a - b;
      thor_pkg::op_addi:    result = a + imm;
      thor_pkg::op_subi:    result = a - imm;
      thor_pkg::op_neg:     result = -a;
      thor_pkg::op_not:     result = ~a;
      // Only the sign bit moves
      thor_pkg::op_fneg:    result = {~a[thor_pkg::data_w-1], a[thor_pkg::data_w-2:0]};
      thor_pkg::op_fabs:    result = {1'b0, a[thor_pkg::data_w-2:0]};
      thor_pkg::op_fsign: begin
        // Plus or minus zero stays zero, else +/-1.0
        if (a[thor_pkg::data_w-2:0] == '0) begin
          result = '0;
        end else begin
          result = thor_pkg::fsign_one;
          result[thor_pkg::data_w-1] = a[thor_pkg::data_w-1];
        end
      end
      thor_pkg::op_and:     result = a & b;
      thor_pkg::op_or:      result = a | b;
      thor_pkg::op_eor:     result = a ^ b;
      thor_pkg::op_nand:    result = ~(a & b);
      thor_pkg::op_nor:     result = ~(a | b);
      // Bitwise equivalence
      thor_pkg::op_enor:    result = ~(a ^ b);
      thor_pkg::op_andi:    result = a & imm;
      thor_pkg::op_ori:     result = a | imm;
      thor_pkg::op_eori:    result = a ^ imm;
      // Bit 0 zero, bit 1 negative
      thor_pkg::op_tst: begin
        result[0] = (a == '0);
        result[1] = a[thor_pkg::data_w-1];
      end
      // Bit 0 equal, bit 1 signed less, bit 2 unsigned less
      thor_pkg::op_cmp: begin
        result[0] = (a == b);
        result[1] = (a_s < b_s);
        result[2] = (a < b);
      end
      thor_pkg::op_cmpi: begin
        result[0] = (a == imm);
        result[1] = (a_s < imm_s);
        result[2] = (a < imm);
      end
      // Base plus displacement
      thor_pkg::op_ea:      result = a + imm;
      // Base plus scaled index plus displacement
      thor_pkg::op_eax1:    result = a + b + imm;
      thor_pkg::op_eax2:    result = a + (b << 1) + imm;
      thor_pkg::op_eax4:    result = a + (b << 2) + imm;
      thor_pkg::op_eax8:    result = a + (b << 3) + imm;
      // Return address is the next instruction
      thor_pkg::op_jsr,
      thor_pkg::op_sys:     result = pc + size_ext;
      thor_pkg::op_int:     result = pc;
      thor_pkg::op_mfspr,
      thor_pkg::op_mtspr:   result = a;
      // A picks B where set, C where clear
      thor_pkg::op_mux:     result = (a & b) | (~a & c);
      default:              result = thor_pkg::bad_op_result;
    endcase
  end

endmodule

//--- logic/thor_exec_top.sv
// Fixed two-cycle latency from issue to result_valid; one issue per cycle at most

`timescale 1ns/1ns

module thor_exec_top (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                issue,
  input  thor_pkg::alu_op_e                   op,
  input  logic [thor_pkg::reg_idx_w-1:0]      ra,
  input  logic [thor_pkg::reg_idx_w-1:0]      rb,
  input  logic [thor_pkg::reg_idx_w-1:0]      rc,
  input  logic [thor_pkg::reg_idx_w-1:0]      rt,
  input  logic [thor_pkg::data_w-1:0]         imm,
  input  logic [thor_pkg::data_w-1:0]         pc,
  input  logic [thor_pkg::insn_size_w-1:0]    insn_size,
  output logic                                result_valid,
  output logic [thor_pkg::data_w-1:0]         result,
  output logic [thor_pkg::reg_idx_w-1:0]      result_reg
);

  // Register file read path
  logic [thor_pkg::reg_idx_w-1:0]   ra0;
  logic [thor_pkg::reg_idx_w-1:0]   ra1;
  logic [thor_pkg::reg_idx_w-1:0]   ra2;
  logic [thor_pkg::data_w-1:0]      rd0;
  logic [thor_pkg::data_w-1:0]      rd1;
  logic [thor_pkg::data_w-1:0]      rd2;

  // Execute stage
  logic                             ex_valid;
  thor_pkg::alu_op_e                ex_op;
  logic [thor_pkg::data_w-1:0]      ex_a;
  logic [thor_pkg::data_w-1:0]      ex_b;
  logic [thor_pkg::data_w-1:0]      ex_c;
  logic [thor_pkg::data_w-1:0]      ex_imm;
  logic [thor_pkg::data_w-1:0]      ex_pc;
  logic [thor_pkg::insn_size_w-1:0] ex_size;
  logic [thor_pkg::reg_idx_w-1:0]   ex_rt;
  logic [thor_pkg::data_w-1:0]      alu_out;

  thor_operand_fetch i_fetch (
    .clk       (clk),
    .reset     (reset),
    .issue     (issue),
    .op        (op),
    .ra        (ra),
    .rb        (rb),
    .rc        (rc),
    .rt        (rt),
    .imm       (imm),
    .pc        (pc),
    .insn_size (insn_size),
    .rd0       (rd0),
    .rd1       (rd1),
    .rd2       (rd2),
    .alu_out   (alu_out),
    .wb_valid  (result_valid),
    .wb_reg    (result_reg),
    .wb_data   (result),
    .ra0       (ra0),
    .ra1       (ra1),
    .ra2       (ra2),
    .ex_valid  (ex_valid),
    .ex_op     (ex_op),
    .ex_a      (ex_a),
    .ex_b      (ex_b),
    .ex_c      (ex_c),
    .ex_imm    (ex_imm),
    .ex_pc     (ex_pc),
    .ex_size   (ex_size),
    .ex_rt     (ex_rt)
  );

  // Write port fed straight from the writeback register
  thor_regfile i_regfile (
    .clk   (clk),
    .reset (reset),
    .ra0   (ra0),
    .ra1   (ra1),
    .ra2   (ra2),
    .we    (result_valid),
    .wa    (result_reg),
    .wd    (result),
    .rd0   (rd0),
    .rd1   (rd1),
    .rd2   (rd2)
  );

  thor_alu i_alu (
    .op        (ex_op),
    .a         (ex_a),
    .b         (ex_b),
    .c         (ex_c),
    .imm       (ex_imm),
    .pc        (ex_pc),
    .insn_size (ex_size),
    .result    (alu_out)
  );

  thor_writeback i_writeback (
    .clk          (clk),
    .reset        (reset),
    .ex_valid     (ex_valid),
    .ex_rt        (ex_rt),
    .alu_out      (alu_out),
    .result_valid (result_valid),
    .result       (result),
    .result_reg   (result_reg)
  );

endmodule

//--- logic/thor_operand_fetch.sv
// Issue fields must be stable while issue is high; forwarding covers execute and writeback only

`timescale 1ns/1ns

module thor_operand_fetch (
  input  logic                                clk,
  input  logic                                reset,
  // Issue side
  input  logic                                issue,
  input  thor_pkg::alu_op_e                   op,
  input  logic [thor_pkg::reg_idx_w-1:0]      ra,
  input  logic [thor_pkg::reg_idx_w-1:0]      rb,
  input  logic [thor_pkg::reg_idx_w-1:0]      rc,
  input  logic [thor_pkg::reg_idx_w-1:0]      rt,
  input  logic [thor_pkg::data_w-1:0]         imm,
  input  logic [thor_pkg::data_w-1:0]         pc,
  input  logic [thor_pkg::insn_size_w-1:0]    insn_size,
  // Register file read data
  input  logic [thor_pkg::data_w-1:0]         rd0,
  input  logic [thor_pkg::data_w-1:0]         rd1,
  input  logic [thor_pkg::data_w-1:0]         rd2,
  // Forwarding sources
  input  logic [thor_pkg::data_w-1:0]         alu_out,
  input  logic                                wb_valid,
  input  logic [thor_pkg::reg_idx_w-1:0]      wb_reg,
  input  logic [thor_pkg::data_w-1:0]         wb_data,
  // Register file read addresses
  output logic [thor_pkg::reg_idx_w-1:0]      ra0,
  output logic [thor_pkg::reg_idx_w-1:0]      ra1,
  output logic [thor_pkg::reg_idx_w-1:0]      ra2,
  // Execute stage
  output logic                                ex_valid,
  output thor_pkg::alu_op_e                   ex_op,
  output logic [thor_pkg::data_w-1:0]         ex_a,
  output logic [thor_pkg::data_w-1:0]         ex_b,
  output logic [thor_pkg::data_w-1:0]         ex_c,
  output logic [thor_pkg::data_w-1:0]         ex_imm,
  output logic [thor_pkg::data_w-1:0]         ex_pc,
  output logic [thor_pkg::insn_size_w-1:0]    ex_size,
  output logic [thor_pkg::reg_idx_w-1:0]      ex_rt
);

  logic [thor_pkg::data_w-1:0] opa;
  logic [thor_pkg::data_w-1:0] opb;
  logic [thor_pkg::data_w-1:0] opc;

  // Youngest producer wins; r0 is hardwired zero
  function automatic logic [thor_pkg::data_w-1:0] fwd(
    input logic [thor_pkg::reg_idx_w-1:0] src,
    input logic [thor_pkg::data_w-1:0]    rf_data
  );
    if (src == '0) begin
      return '0;
    end else if (ex_valid && (ex_rt == src)) begin
      return alu_out;
    end else if (wb_valid && (wb_reg == src)) begin
      return wb_data;
    end
    return rf_data;
  endfunction

  assign ra0 = ra;
  assign ra1 = rb;
  assign ra2 = rc;

  // Operand select follows the forwarding sources as well as the read data
  always_comb begin
    opa = fwd(ra, rd0);
    opb = fwd(rb, rd1);
    opc = fwd(rc, rd2);
  end

  // ======================================================================
  // Execute stage register
  // ======================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue;
    end
  end

  // Payload captured only on a real issue
  always_ff @(posedge clk) begin
    if (issue) begin
      ex_op   <= op;
      ex_a    <= opa;
      ex_b    <= opb;
      ex_c    <= opc;
      ex_imm  <= imm;
      ex_pc   <= pc;
      ex_size <= insn_size;
      ex_rt   <= rt;
    end
  end

endmodule

//--- logic/thor_pkg.sv
// Shared constants and opcodes for the execute lane; data width fixed at 64, 16 registers

package thor_pkg;

  // ======================================================================
  // Sizes
  // ======================================================================

  // Data and address width
  localparam int data_w = 64;

  // Register file depth and index width
  localparam int reg_count = 16;
  localparam int reg_idx_w = 4;

  // Instruction size field, in bytes
  localparam int insn_size_w = 4;

  // ======================================================================
  // Result constants
  // ======================================================================

  // Returned for any opcode the ALU does not decode
  localparam logic [data_w-1:0] bad_op_result = 64'hDEAD_DEAD_DEAD_DEAD;

  // Double 1.0 with sign cleared; FSIGN ORs in the operand sign
  localparam logic [data_w-1:0] fsign_one = 64'h3FF0_0000_0000_0000;

  // ======================================================================
  // Opcodes
  // ======================================================================

  // Signed/unsigned synonyms share one literal
  // Load/store variants collapse onto their address form
  typedef enum logic [7:0] {
    op_ldi     = 8'h01,
    // Register and immediate arithmetic
    op_add     = 8'h10,
    op_sub     = 8'h11,
    op_addi    = 8'h12,
    op_subi    = 8'h13,
    op_neg     = 8'h14,
    op_not     = 8'h15,
    // Scaled unsigned adds, A shifted left by 1..4
    op_addu2   = 8'h18,
    op_addu4   = 8'h19,
    op_addu8   = 8'h1A,
    op_addu16  = 8'h1B,
    op_addui2  = 8'h1C,
    op_addui4  = 8'h1D,
    op_addui8  = 8'h1E,
    op_addui16 = 8'h1F,
    // Sign bit games on IEEE doubles
    op_fneg    = 8'h20,
    op_fabs    = 8'h21,
    op_fsign   = 8'h22,
    // Bitwise logic
    op_and     = 8'h30,
    op_or      = 8'h31,
    op_eor     = 8'h32,
    op_nand    = 8'h33,
    op_nor     = 8'h34,
    op_enor    = 8'h35,
    op_andi    = 8'h36,
    op_ori     = 8'h37,
    op_eori    = 8'h38,
    // Flag producing ops
    op_tst     = 8'h40,
    op_cmp     = 8'h41,
    op_cmpi    = 8'h42,
    // Effective addresses, plain and indexed by byte/char/half/word
    op_ea      = 8'h50,
    op_eax1    = 8'h51,
    op_eax2    = 8'h52,
    op_eax4    = 8'h53,
    op_eax8    = 8'h54,
    // Flow related values
    op_jsr     = 8'h60,
    op_sys     = 8'h61,
    op_int     = 8'h62,
    // Special register pass-through
    op_mfspr   = 8'h63,
    op_mtspr   = 8'h64,
    op_mux     = 8'h70
  } alu_op_e;

endpackage

//--- logic/thor_regfile.sv
// Register 0 reads zero and ignores writes; reads are combinational, so no write-through

`timescale 1ns/1ns

module thor_regfile (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [thor_pkg::reg_idx_w-1:0]    ra0,
  input  logic [thor_pkg::reg_idx_w-1:0]    ra1,
  input  logic [thor_pkg::reg_idx_w-1:0]    ra2,
  input  logic                              we,
  input  logic [thor_pkg::reg_idx_w-1:0]    wa,
  input  logic [thor_pkg::data_w-1:0]       wd,
  output logic [thor_pkg::data_w-1:0]       rd0,
  output logic [thor_pkg::data_w-1:0]       rd1,
  output logic [thor_pkg::data_w-1:0]       rd2
);

  logic [thor_pkg::data_w-1:0] regs [thor_pkg::reg_count];

  // Effective write strobe, register 0 filtered out
  logic reg_write;

  assign reg_write = we && (wa != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < thor_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write) begin
      regs[wa] <= wd;
    end
  end

  // Three read ports
  assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

//--- logic/thor_writeback.sv
// Result is held only for the single valid cycle; there is no back-pressure

`timescale 1ns/1ns

module thor_writeback (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              ex_valid,
  input  logic [thor_pkg::reg_idx_w-1:0]    ex_rt,
  input  logic [thor_pkg::data_w-1:0]       alu_out,
  output logic                              result_valid,
  output logic [thor_pkg::data_w-1:0]       result,
  output logic [thor_pkg::reg_idx_w-1:0]    result_reg
);

  // One cycle pulse per executed instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= ex_valid;
    end
  end

  // Result and destination, doubling as the write port
  always_ff @(posedge clk) begin
    if (ex_valid) begin
      result     <= alu_out;
      result_reg <= ex_rt;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_thor_exec -f build.f
status=0
./obj_dir/Vtb_thor_exec > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log \
    || ! grep -q "Test completed successfully" sim.log; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi
echo "Simulation passed"

//--- verification/exec_trace.txt
# gap op ra rb rc rt imm pc insn_size expected, all hex
# gap is idle cycles before the issue; gap 0 lines are issued back to back
1 01 0 0 0 1 64 0 0 64
1 01 0 0 0 2 3 0 0 3
1 01 0 0 0 3 FFFFFFFFFFFFFFF0 0 0 FFFFFFFFFFFFFFF0
1 01 0 0 0 4 0F0F0F0F0F0F0F0F 0 0 0F0F0F0F0F0F0F0F
1 01 0 0 0 5 3FF8000000000000 0 0 3FF8000000000000
1 01 0 0 0 6 8000000000000000 0 0 8000000000000000
1 10 1 2 0 7 0 0 0 67
1 11 2 1 0 8 0 0 0 FFFFFFFFFFFFFF9F
1 12 1 0 0 9 10 0 0 74
1 13 3 0 0 7 10 0 0 FFFFFFFFFFFFFFE0
1 14 1 0 0 8 0 0 0 FFFFFFFFFFFFFF9C
1 15 4 0 0 9 0 0 0 F0F0F0F0F0F0F0F0
1 18 1 2 0 7 0 0 0 CB
1 19 1 2 0 8 0 0 0 193
1 1A 1 2 0 9 0 0 0 323
1 1B 1 2 0 7 0 0 0 643
1 1C 2 0 0 8 100 0 0 106
1 1D 2 0 0 9 100 0 0 10C
1 1E 2 0 0 7 100 0 0 118
1 1F 2 0 0 8 100 0 0 130
1 30 4 3 0 9 0 0 0 0F0F0F0F0F0F0F00
1 31 4 1 0 7 0 0 0 0F0F0F0F0F0F0F6F
1 32 4 3 0 8 0 0 0 F0F0F0F0F0F0F0FF
1 33 4 3 0 9 0 0 0 F0F0F0F0F0F0F0FF
1 34 4 1 0 7 0 0 0 F0F0F0F0F0F0F090
1 35 4 3 0 8 0 0 0 0F0F0F0F0F0F0F00
1 36 4 0 0 9 FF 0 0 F
1 37 1 0 0 7 F00 0 0 F64
1 38 4 0 0 8 FFFF 0 0 0F0F0F0F0F0FF0F0
1 40 0 0 0 7 0 0 0 1
1 40 3 0 0 8 0 0 0 2
1 40 1 0 0 9 0 0 0 0
1 41 1 1 0 7 0 0 0 1
1 41 3 1 0 8 0 0 0 2
1 41 1 3 0 9 0 0 0 4
1 42 2 0 0 7 3 0 0 1
1 42 2 0 0 8 10 0 0 6
1 42 3 0 0 9 5 0 0 2
1 20 5 0 0 9 0 0 0 BFF8000000000000
1 21 6 0 0 7 0 0 0 0
1 21 3 0 0 8 0 0 0 7FFFFFFFFFFFFFF0
1 22 5 0 0 9 0 0 0 3FF0000000000000
1 22 6 0 0 7 0 0 0 0
1 22 3 0 0 8 0 0 0 BFF0000000000000
1 50 1 0 0 7 8 0 0 6C
1 51 1 2 0 8 8 0 0 6F
1 52 1 2 0 9 8 0 0 72
1 53 1 2 0 7 8 0 0 78
1 54 1 2 0 8 8 0 0 84
1 60 0 0 0 9 0 1000 4 1004
1 61 0 0 0 7 0 2000 8 2008
1 62 0 0 0 8 0 3000 0 3000
1 63 1 0 0 9 0 0 0 64
1 70 4 3 1 7 0 0 0 0F0F0F0F0F0F0F60
1 FF 0 0 0 8 0 0 0 DEADDEADDEADDEAD
2 01 0 0 0 A 5 0 0 5
0 01 0 0 0 B 7 0 0 7
0 10 A B 0 C 0 0 0 C
0 10 A C 0 D 0 0 0 11
0 10 C D 0 E 0 0 0 1D
0 11 E B 0 A 0 0 0 16
0 10 A A 0 F 0 0 0 2C
0 12 A 0 0 A 1 0 0 17
0 12 A 0 0 9 0 0 0 17
0 12 F 0 0 9 0 0 0 2C
2 01 0 0 0 0 1234 0 0 1234
0 12 0 0 0 7 5 0 0 5
0 10 0 2 0 8 0 0 0 3
3 37 0 0 0 9 40 0 0 40

//--- verification/tb_clock_gen.sv
// Free-running 4 ns clock; reset is synchronous, held high for the first three rising edges

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam int half_period  = 2;
  localparam int reset_cycles = 3;

  // Clock starts low so the first rising edge lands at 2 ns
  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Released on a rising edge, like any other synchronous input
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- verification/tb_thor_exec.sv
// Run from the project root so the trace path resolves; expects the fixed two-cycle latency

`timescale 1ns/1ns

module tb_thor_exec;

  localparam int clk_period = 4;
  // Extra idle cycles drawn at random, only where the trace allows a gap
  localparam int max_extra_gap = 2;

  // One parsed trace line
  typedef struct {
    int                                gap;
    logic [7:0]                        op;
    logic [thor_pkg::reg_idx_w-1:0]    ra;
    logic [thor_pkg::reg_idx_w-1:0]    rb;
    logic [thor_pkg::reg_idx_w-1:0]    rc;
    logic [thor_pkg::reg_idx_w-1:0]    rt;
    logic [thor_pkg::data_w-1:0]       imm;
    logic [thor_pkg::data_w-1:0]       pc;
    logic [thor_pkg::insn_size_w-1:0]  insn_size;
    logic [thor_pkg::data_w-1:0]       expected;
  } trace_line_t;

  logic                               clk;
  logic                               reset;
  logic                               issue;
  thor_pkg::alu_op_e                  op;
  logic [thor_pkg::reg_idx_w-1:0]     ra;
  logic [thor_pkg::reg_idx_w-1:0]     rb;
  logic [thor_pkg::reg_idx_w-1:0]     rc;
  logic [thor_pkg::reg_idx_w-1:0]     rt;
  logic [thor_pkg::data_w-1:0]        imm;
  logic [thor_pkg::data_w-1:0]        pc;
  logic [thor_pkg::insn_size_w-1:0]   insn_size;
  logic                               result_valid;
  logic [thor_pkg::data_w-1:0]        result;
  logic [thor_pkg::reg_idx_w-1:0]     result_reg;

  // Trace and the in-flight expectations, oldest first
  trace_line_t                        trace[$];
  logic [thor_pkg::data_w-1:0]        exp_result_q[$];
  logic [thor_pkg::reg_idx_w-1:0]     exp_reg_q[$];

  int     value_errors = 0;
  int     stray_results = 0;
  int     missing_results = 0;
  int     max_trace_gap = 0;
  bit     trace_ready = 1'b0;
  integer seed = 60;

  tb_clock_gen i_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  thor_exec_top i_thor_exec_top (
    .clk          (clk),
    .reset        (reset),
    .issue        (issue),
    .op           (op),
    .ra           (ra),
    .rb           (rb),
    .rc           (rc),
    .rt           (rt),
    .imm          (imm),
    .pc           (pc),
    .insn_size    (insn_size),
    .result_valid (result_valid),
    .result       (result),
    .result_reg   (result_reg)
  );

  bind thor_exec_top thor_exec_assertions i_exec_assertions (
    .clk          (clk),
    .reset        (reset),
    .issue        (issue),
    .result_valid (result_valid),
    .result_reg   (result_reg),
    .reg0         (i_regfile.regs[0])
  );

  // ======================================================================
  // Helpers
  // ======================================================================

  task automatic check_value(
    input string                       what,
    input logic [thor_pkg::data_w-1:0] got,
    input logic [thor_pkg::data_w-1:0] exp
  );
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      value_errors++;
    end
  endtask

  // Ten hex columns per line; lines starting with # are skipped
  task automatic load_trace(output bit ok);
    int          fd;
    int          fields;
    string       line;
    logic [63:0] f_gap;
    logic [63:0] f_op;
    logic [63:0] f_ra;
    logic [63:0] f_rb;
    logic [63:0] f_rc;
    logic [63:0] f_rt;
    logic [63:0] f_imm;
    logic [63:0] f_pc;
    logic [63:0] f_size;
    logic [63:0] f_exp;
    trace_line_t entry;
    ok = 1'b0;
    fd = $fopen("verification/exec_trace.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        fields = 0;
        if ((line.len() > 0) && (line.getc(0) != "#")) begin
          fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                           f_gap, f_op, f_ra, f_rb, f_rc, f_rt, f_imm, f_pc, f_size, f_exp);
        end
        if (fields == 10) begin
          entry.gap       = int'(f_gap[15:0]);
          entry.op        = f_op[7:0];
          entry.ra        = f_ra[thor_pkg::reg_idx_w-1:0];
          entry.rb        = f_rb[thor_pkg::reg_idx_w-1:0];
          entry.rc        = f_rc[thor_pkg::reg_idx_w-1:0];
          entry.rt        = f_rt[thor_pkg::reg_idx_w-1:0];
          entry.imm       = f_imm;
          entry.pc        = f_pc;
          entry.insn_size = f_size[thor_pkg::insn_size_w-1:0];
          entry.expected  = f_exp;
          trace.push_back(entry);
          if (entry.gap > max_trace_gap) begin
            max_trace_gap = entry.gap;
          end
        end
      end
      $fclose(fd);
      ok = (trace.size() > 0);
    end
  endtask

  // Gap 0 lines stay back to back so the forwarding paths are hit
  task automatic run_trace();
    int          extra;
    trace_line_t t;
    for (int i = 0; i < trace.size(); i++) begin
      t = trace[i];
      extra = (t.gap == 0) ? 0 : int'($unsigned($random(seed)) % (max_extra_gap + 1));
      repeat (t.gap + extra) begin
        @(posedge clk);
        issue <= 1'b0;
      end
      @(posedge clk);
      issue     <= 1'b1;
      op        <= thor_pkg::alu_op_e'(t.op);
      ra        <= t.ra;
      rb        <= t.rb;
      rc        <= t.rc;
      rt        <= t.rt;
      imm       <= t.imm;
      pc        <= t.pc;
      insn_size <= t.insn_size;
      exp_result_q.push_back(t.expected);
      exp_reg_q.push_back(t.rt);
    end
    @(posedge clk);
    issue <= 1'b0;
  endtask

  // ======================================================================
  // Result monitor
  // ======================================================================
  always @(posedge clk) begin : result_monitor
    logic [thor_pkg::data_w-1:0]    exp_value;
    logic [thor_pkg::reg_idx_w-1:0] exp_reg;
    if (!reset && result_valid) begin
      if (exp_result_q.size() == 0) begin
        $display("Error at %0t ns: result_valid pulsed with no instruction in flight", $time);
        stray_results++;
      end else begin
        exp_value = exp_result_q.pop_front();
        exp_reg = exp_reg_q.pop_front();
        check_value("result", result, exp_value);
        check_value("result_reg", {60'd0, result_reg}, {60'd0, exp_reg});
      end
    end
  end

  // ======================================================================
  // Main flow
  // ======================================================================
  initial begin : main_flow
    bit loaded;
    issue     = 1'b0;
    op        = thor_pkg::op_ldi;
    ra        = '0;
    rb        = '0;
    rc        = '0;
    rt        = '0;
    imm       = '0;
    pc        = '0;
    insn_size = '0;
    load_trace(loaded);
    if (!loaded) begin
      $display("Error: the trace file could not be opened or holds no instructions");
      $display("Test failed");
      $finish;
    end else begin
      trace_ready = 1'b1;
      // Reset is only looked at on clock edges, once it has a value
      @(posedge clk);
      while (reset) begin
        @(posedge clk);
      end
      run_trace();
      // Two-cycle latency plus margin
      repeat (4) @(posedge clk);
      missing_results = exp_result_q.size();
      if (missing_results != 0) begin
        $display("Error: %0d expected results never arrived", missing_results);
      end
      $display("Summary: %0d value mismatches, %0d unexpected results, %0d missing results",
               value_errors, stray_results, missing_results);
      if ((value_errors == 0) && (stray_results == 0) && (missing_results == 0)) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

  // Every line costs at most its gap plus one issue cycle
  initial begin : watchdog
    longint limit_cycles;
    wait (trace_ready);
    limit_cycles = longint'(trace.size()) * (max_trace_gap + max_extra_gap + 1) + 20;
    #(limit_cycles * clk_period);
    $display("Error: watchdog expired after %0d cycles, the run did not finish", limit_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

//--- verification/thor_exec_assertions.sv
// Bound into thor_exec_top; reg0 is tapped from register 0 storage of the register file by the bind

`timescale 1ns/1ns

module thor_exec_assertions (
  input logic                              clk,
  input logic                              reset,
  input logic                              issue,
  input logic                              result_valid,
  input logic [thor_pkg::reg_idx_w-1:0]    result_reg,
  input logic [thor_pkg::data_w-1:0]       reg0
);

  // ======================================================================
  // Result pulse shape
  // ======================================================================

  // A lone issue gives one pulse, two edges later, and no second cycle
  single_result_pulse: assert property (
    @(posedge clk) disable iff (reset)
    (issue ##1 !issue) |-> ##1 result_valid ##1 !result_valid
  ) else $error("result_valid missing or held for two cycles after a lone issue");

  // Whole valid chain clears, so nothing comes out in reset or the cycle after
  quiet_in_reset: assert property (
    @(posedge clk) reset |=> (!result_valid) [*2]
  ) else $error("result_valid high during reset or right after it");

  // ======================================================================
  // Register 0
  // ======================================================================

  // A result for register 0 leaves its storage at zero
  r0_stays_zero: assert property (
    @(posedge clk) disable iff (reset)
    (result_valid && (result_reg == '0)) |=> (reg0 == '0)
  ) else $error("register 0 storage changed by a write to register 0");

endmodule
